// File: core_top.f
+incdir+source
source/core_pkg.sv
source/bypass_if.sv
source/stage_if.sv
source/stage_id.sv
source/stage_ex.sv
source/stage_mm.sv
source/core_top.sv
verification/tb_clock.sv
verification/core_top_tb.sv

// File: Makefile
SIM = obj_dir/core_top_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module core_top_tb \
		-f core_top.f -Mdir obj_dir -o core_top_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

// File: verification/core_top_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_top_tb;
    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_STORE  = 7'b0100011;
    localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
    localparam logic [6:0]  OPC_JAL    = 7'b1101111;
    localparam logic [31:0] HALT       = 32'h0000_006f; // jal x0, 0 spins in place
    localparam int          DAW        = $clog2(`DMEM_DEPTH);

    logic        clk, rst_n, reset_req;
    logic        run, imem_we, wb_valid;
    logic [31:0] imem_addr, imem_wdata, pc, wb_data;
    logic [4:0]  wb_rd;

    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [`DMEM_DEPTH];
    logic [31:0] lfsr_state = 32'h852d65df;
    logic [4:0]  want_rd;
    logic [31:0] want_val;
    int          err_count = 0;
    int          extra_wb = 0;
    int          test_count = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    tb_clock clock_i (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

    core_top core_top_i (
        .clk(clk), .rst_n(rst_n), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .pc(pc), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        rand_bits = v;
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        r_word = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        i_word = {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] s_word(input int rs2, input int rs1, input int imm);
        logic [11:0] im;
        im     = 12'(imm);
        s_word = {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_word(input int rs1, input int rs2, input int off);
        logic [12:0] im;
        im     = 13'(off);
        b_word = {im[12], im[10:5], 5'(rs2), 5'(rs1), 3'b000, im[4:1], im[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input int rd, input int off);
        logic [20:0] im;
        im     = 21'(off);
        j_word = {im[20], im[10:1], im[11], im[19:12], 5'(rd), OPC_JAL};
    endfunction

    // Integer ops as the ISA defines them
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  alu_ref = alt ? a - b : a + b;
            3'b001:  alu_ref = a << b[4:0];
            3'b010:  alu_ref = {31'b0, $signed(a) < $signed(b)};
            3'b100:  alu_ref = a ^ b;
            3'b101:  alu_ref = a >> b[4:0];
            3'b110:  alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    // Runs prog to HALT and queues every register write in order
    task automatic interpret_program();
        logic [31:0] ins, a, b, res, addr, pc_m, next_pc;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic [4:0]  rd;
        logic        wr, done;
        int          steps, idx;
        for (int k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
        for (int k = 0; k < `DMEM_DEPTH; k++) begin
            ref_mem[k] = '0;
        end
        exp_rd.delete();
        exp_val.delete();
        pc_m  = '0;
        steps = 0;
        done  = 1'b0;
        while (!done) begin
            idx = int'(pc_m >> 2);
            if (idx >= prog.size() || steps > 500) begin
                $display("Reference model ran past the program at pc %h", pc_m);
                err_count++;
                done = 1'b1;
            end else if (prog[idx] == HALT) begin
                done = 1'b1;
            end else begin
                ins     = prog[idx];
                rd      = ins[11:7];
                a       = ref_regs[ins[19:15]];
                b       = ref_regs[ins[24:20]];
                imm_i   = {{20{ins[31]}}, ins[31:20]};
                imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                next_pc = pc_m + 32'd4;
                wr      = 1'b0;
                res     = '0;
                case (ins[6:0])
                    OPC_OP: begin
                        res = alu_ref(ins[14:12], ins[30], a, b);
                        wr  = 1'b1;
                    end
                    OPC_IMM: begin
                        res = alu_ref(ins[14:12], 1'b0, a, imm_i);
                        wr  = 1'b1;
                    end
                    OPC_LOAD: begin
                        addr = a + imm_i;
                        res  = ref_mem[addr[DAW+1:2]];
                        wr   = 1'b1;
                    end
                    OPC_STORE: begin
                        addr = a + imm_s;
                        ref_mem[addr[DAW+1:2]] = b;
                    end
                    OPC_BRANCH: begin
                        if (a == b) begin
                            next_pc = pc_m + imm_b;
                        end
                    end
                    OPC_JAL: begin
                        res     = pc_m + 32'd4; // Link
                        wr      = 1'b1;
                        next_pc = pc_m + imm_j;
                    end
                    default: ;
                endcase
                if (wr && rd != 5'd0) begin
                    ref_regs[rd] = res;
                    exp_rd.push_back(rd);
                    exp_val.push_back(res);
                end
                pc_m = next_pc;
                steps++;
            end
        end
    endtask

    // Unused words become address-tagged no-ops
    task automatic load_program();
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i * 4;
            imem_wdata <= (i < prog.size()) ? prog[i] : i_word(OPC_IMM, 3'b000, 0, 0, i);
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic reset_core();
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(negedge clk);
        while (!rst_n) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic check_reset_idle();
        int errs_before;
        errs_before = err_count;
        cycle_limit += 40;
        reset_core();
        repeat (8) begin
            @(negedge clk);
            assert (wb_valid == 1'b0) else begin
                $display("** Error at %0t: wb_valid = %b, expected 0", $time, wb_valid);
                err_count++;
            end
            assert (pc == 32'd0) else begin
                $display("** Error at %0t: pc = %h, expected 00000000", $time, pc);
                err_count++;
            end
        end
        report_test("reset_idle", errs_before);
    endtask

    task automatic run_program(input string name);
        int errs_before;
        errs_before = err_count;
        cycle_limit += 20 * prog.size() + `IMEM_DEPTH + 40;
        interpret_program();
        load_program();
        reset_core();
        extra_wb = 0;
        @(posedge clk);
        run <= 1'b1;
        while (exp_rd.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        assert (extra_wb == 0) else begin
            $display("Core wrote back %0d registers beyond the expected list", extra_wb);
            err_count++;
        end
        run <= 1'b0;
        repeat (4) @(posedge clk); // Let the HALT loop drain
        report_test(name, errs_before);
    endtask

    // Writebacks are compared in program order
    always @(negedge clk) begin
        if (wb_valid) begin
            if (exp_rd.size() == 0) begin
                extra_wb++;
            end else begin
                want_rd  = exp_rd.pop_front();
                want_val = exp_val.pop_front();
                assert (wb_rd == want_rd) else begin
                    $display("** Error at %0t: wb_rd = %0d, expected %0d", $time, wb_rd, want_rd);
                    err_count++;
                end
                assert (wb_data == want_val) else begin
                    $display("** Error at %0t: wb_data = %h, expected %h",
                             $time, wb_data, want_val);
                    err_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, expected writebacks never arrived", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int base;
        reset_req  = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;

        check_reset_idle();

        // Seeds with x1 forced negative
        prog.delete();
        prog.push_back(i_word(OPC_IMM, 3'b000, 1, 0, int'(rand_bits(11) | 32'h800)));
        for (int k = 2; k <= 4; k++) begin
            prog.push_back(i_word(OPC_IMM, 3'b000, k, 0, int'(rand_bits(12))));
        end
        prog.push_back(r_word(7'h00, 3'b000, 5, 1, 2));  // ADD
        prog.push_back(r_word(7'h20, 3'b000, 6, 1, 2));  // SUB
        prog.push_back(r_word(7'h00, 3'b111, 7, 1, 3));
        prog.push_back(r_word(7'h00, 3'b110, 8, 2, 3));
        prog.push_back(r_word(7'h00, 3'b100, 9, 1, 4));
        prog.push_back(r_word(7'h00, 3'b010, 10, 1, 0)); // SLT with a negative operand
        prog.push_back(r_word(7'h00, 3'b010, 11, 2, 1));
        prog.push_back(r_word(7'h00, 3'b001, 12, 2, 3)); // SLL
        prog.push_back(r_word(7'h00, 3'b101, 13, 1, 3)); // SRL of a negative value
        prog.push_back(r_word(7'h00, 3'b101, 14, 12, 3));
        prog.push_back(HALT);
        run_program("alu_ops");

        prog.delete();
        prog.push_back(i_word(OPC_IMM, 3'b000, 1, 0, int'(rand_bits(12))));
        prog.push_back(r_word(7'h00, 3'b000, 2, 1, 1));  // Distance 1
        prog.push_back(r_word(7'h20, 3'b000, 3, 2, 1));  // Distance 1 and 2
        prog.push_back(r_word(7'h00, 3'b100, 4, 3, 2));
        prog.push_back(i_word(OPC_IMM, 3'b000, 5, 0, int'(rand_bits(12))));
        prog.push_back(i_word(OPC_IMM, 3'b000, 0, 0, 0));
        prog.push_back(r_word(7'h00, 3'b000, 6, 5, 4));  // Distance 2 and 3
        prog.push_back(r_word(7'h00, 3'b110, 7, 6, 6));
        prog.push_back(i_word(OPC_IMM, 3'b000, 7, 7, int'(rand_bits(12))));
        prog.push_back(HALT);
        run_program("forwarding");

        base = 64 + 4 * int'(rand_bits(4));
        prog.delete();
        prog.push_back(i_word(OPC_IMM, 3'b000, 1, 0, base));
        prog.push_back(i_word(OPC_IMM, 3'b000, 2, 0, int'(rand_bits(12))));
        prog.push_back(s_word(2, 1, 0));
        prog.push_back(s_word(1, 1, -4));
        prog.push_back(i_word(OPC_LOAD, 3'b010, 3, 1, 0));
        prog.push_back(r_word(7'h00, 3'b000, 4, 3, 3)); // Load-use
        prog.push_back(i_word(OPC_LOAD, 3'b010, 5, 1, -4));
        prog.push_back(s_word(5, 1, 8));                // Loaded value as store data
        prog.push_back(i_word(OPC_LOAD, 3'b010, 6, 1, 8));
        prog.push_back(i_word(OPC_IMM, 3'b000, 7, 6, 1));
        prog.push_back(HALT);
        run_program("load_store");

        prog.delete();
        base = int'(rand_bits(12));
        prog.push_back(i_word(OPC_IMM, 3'b000, 1, 0, base));
        prog.push_back(i_word(OPC_IMM, 3'b000, 2, 0, base));
        prog.push_back(b_word(1, 2, 8));                // Taken
        prog.push_back(i_word(OPC_IMM, 3'b000, 3, 0, 1));
        prog.push_back(j_word(4, 8));
        prog.push_back(i_word(OPC_IMM, 3'b000, 5, 0, 2));
        prog.push_back(i_word(OPC_IMM, 3'b000, 6, 1, 1));
        prog.push_back(b_word(1, 6, 8));                // Not taken
        prog.push_back(i_word(OPC_IMM, 3'b000, 7, 0, 3));
        prog.push_back(r_word(7'h00, 3'b000, 8, 4, 7));
        prog.push_back(HALT);
        run_program("branch_jump");

        $display("Tests run %0d, failed %0d, errors %0d", test_count, tests_failed, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

// Free-running clock, reset low at start and again on request
module tb_clock (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);
    int rst_left = 4; // Rising edges still to spend in reset

    initial clk = 1'b0;

    always #5 clk = ~clk; // 10 ns period

    always @(posedge clk) begin
        if (reset_req) begin
            rst_left <= 4;
        end else if (rst_left != 0) begin
            rst_left <= rst_left - 1;
        end
    end

    assign rst_n = (rst_left == 0);

endmodule

// File: source/core_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,
    input  logic                        imem_we,
    input  logic [`XLEN-1:0]            imem_addr,
    input  logic [31:0]                 imem_wdata,
    output logic [`XLEN-1:0]            pc,
    output logic                        wb_valid,
    output logic [$clog2(`REG_NUM)-1:0] wb_rd,
    output logic [`XLEN-1:0]            wb_data
);
    localparam int RAW = $clog2(`REG_NUM);

    logic [31:0]      if_inst;
    logic             if_valid;
    logic             stall;
    logic             redirect;
    logic [`XLEN-1:0] target;

    core_pkg::ctrl_t  ex_ctrl;
    logic [RAW-1:0]   ex_rd;
    logic [`XLEN-1:0] ex_a, ex_b, ex_store, ex_pc4;
    logic             ex_valid;

    core_pkg::ctrl_t  mm_ctrl;
    logic [RAW-1:0]   mm_rd;
    logic [`XLEN-1:0] mm_result, mm_store;
    logic             mm_valid;

    bypass_if byp ();

    stage_if stage_if_i (
        .clk(clk), .rst_n(rst_n), .run(run), .stall(stall),
        .redirect(redirect), .target(target),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .pc(pc), .inst(if_inst), .inst_valid(if_valid)
    );

    stage_id stage_id_i (
        .clk(clk), .rst_n(rst_n), .pc(pc), .inst(if_inst), .inst_valid(if_valid),
        .byp(byp.decode),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), // Writeback port
        .stall(stall), .redirect(redirect), .target(target),
        .ex_ctrl(ex_ctrl), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
        .ex_store(ex_store), .ex_pc4(ex_pc4), .ex_valid(ex_valid)
    );

    stage_ex stage_ex_i (
        .clk(clk), .rst_n(rst_n),
        .ex_ctrl(ex_ctrl), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
        .ex_store(ex_store), .ex_pc4(ex_pc4), .ex_valid(ex_valid),
        .byp(byp.execute),
        .mm_ctrl(mm_ctrl), .mm_rd(mm_rd), .mm_result(mm_result),
        .mm_store(mm_store), .mm_valid(mm_valid)
    );

    stage_mm stage_mm_i (
        .clk(clk), .rst_n(rst_n),
        .mm_ctrl(mm_ctrl), .mm_rd(mm_rd), .mm_result(mm_result),
        .mm_store(mm_store), .mm_valid(mm_valid),
        .byp(byp.memory),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// File: source/stage_mm.sv
`timescale 1ns/1ps
`include "core_config.svh"

module stage_mm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  core_pkg::ctrl_t             mm_ctrl,
    input  logic [$clog2(`REG_NUM)-1:0] mm_rd,
    input  logic [`XLEN-1:0]            mm_result,
    input  logic [`XLEN-1:0]            mm_store,
    input  logic                        mm_valid,
    bypass_if.memory                    byp,
    output logic                        wb_valid,
    output logic [$clog2(`REG_NUM)-1:0] wb_rd,
    output logic [`XLEN-1:0]            wb_data
);
    localparam int DAW = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0] dmem [`DMEM_DEPTH];
    logic [DAW-1:0]   dm_idx;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] sel_data;
    logic             wr_en;

    assign dm_idx = mm_result[DAW+1:2]; // Word index from the computed address

    always_ff @(posedge clk) begin
        if (mm_valid && mm_ctrl.mem_write) begin
            dmem[dm_idx] <= mm_store;
        end
    end

    assign load_data = dmem[dm_idx];

    // Writeback select, also what decode sees as mm_data
    assign sel_data = mm_ctrl.mem_read ? load_data : mm_result;

    assign wr_en = mm_valid && mm_ctrl.reg_write && (mm_rd != '0);

    assign byp.mm_rd        = mm_rd;
    assign byp.mm_reg_write = wr_en;
    assign byp.mm_data      = sel_data;

    // MEM/WB
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mm_rd;
        wb_data <= sel_data;
    end

endmodule

// File: source/stage_ex.sv
`timescale 1ns/1ps
`include "core_config.svh"

module stage_ex (
    input  logic                        clk,
    input  logic                        rst_n,
    input  core_pkg::ctrl_t             ex_ctrl,
    input  logic [$clog2(`REG_NUM)-1:0] ex_rd,
    input  logic [`XLEN-1:0]            ex_a,
    input  logic [`XLEN-1:0]            ex_b,
    input  logic [`XLEN-1:0]            ex_store,
    input  logic [`XLEN-1:0]            ex_pc4,
    input  logic                        ex_valid,
    bypass_if.execute                   byp,
    output core_pkg::ctrl_t             mm_ctrl,
    output logic [$clog2(`REG_NUM)-1:0] mm_rd,
    output logic [`XLEN-1:0]            mm_result,
    output logic [`XLEN-1:0]            mm_store,
    output logic                        mm_valid
);
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_y;
    logic             wr_en;

    // JAL link value enters as operand a
    assign alu_a = ex_ctrl.is_jal ? ex_pc4 : ex_a;

    always_comb begin
        case (ex_ctrl.alu_op)
            core_pkg::ALU_ADD: alu_y = alu_a + ex_b;
            core_pkg::ALU_SUB: alu_y = alu_a - ex_b;
            core_pkg::ALU_AND: alu_y = alu_a & ex_b;
            core_pkg::ALU_OR:  alu_y = alu_a | ex_b;
            core_pkg::ALU_XOR: alu_y = alu_a ^ ex_b;
            core_pkg::ALU_SLT: alu_y = `XLEN'($signed(alu_a) < $signed(ex_b));
            core_pkg::ALU_SLL: alu_y = alu_a << ex_b[4:0];
            core_pkg::ALU_SRL: alu_y = alu_a >> ex_b[4:0];
            default:           alu_y = '0;
        endcase
    end

    assign wr_en = ex_valid && ex_ctrl.reg_write && (ex_rd != '0);

    assign byp.ex_rd        = ex_rd;
    assign byp.ex_reg_write = wr_en;
    assign byp.ex_is_load   = wr_en && ex_ctrl.mem_read; // Decode stalls on this one
    assign byp.ex_result    = alu_y;

    // EX/MEM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_valid <= 1'b0;
            mm_ctrl  <= '0;
        end else begin
            mm_valid <= ex_valid;
            mm_ctrl  <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        mm_rd     <= ex_rd;
        mm_result <= alu_y;
        mm_store  <= ex_store;
    end

endmodule

// File: source/stage_id.sv
`timescale 1ns/1ps
`include "core_config.svh"

module stage_id (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`XLEN-1:0]            pc,
    input  core_pkg::inst_u             inst,
    input  logic                        inst_valid,
    bypass_if.decode                    byp,
    input  logic                        wb_valid,
    input  logic [$clog2(`REG_NUM)-1:0] wb_rd,
    input  logic [`XLEN-1:0]            wb_data,
    output logic                        stall,
    output logic                        redirect,
    output logic [`XLEN-1:0]            target,
    output core_pkg::ctrl_t             ex_ctrl,
    output logic [$clog2(`REG_NUM)-1:0] ex_rd,
    output logic [`XLEN-1:0]            ex_a,
    output logic [`XLEN-1:0]            ex_b,
    output logic [`XLEN-1:0]            ex_store,
    output logic [`XLEN-1:0]            ex_pc4,
    output logic                        ex_valid
);
    localparam int RAW = $clog2(`REG_NUM);

    logic [`XLEN-1:0] id_pc;
    core_pkg::inst_u  id_inst;
    logic             id_valid;

    logic [`XLEN-1:0] regs [`REG_NUM];
    logic [RAW-1:0]   rs [2];
    logic [`XLEN-1:0] opnd [2];

    core_pkg::ctrl_t  dec;
    core_pkg::ctrl_t  ctrl;
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
    logic             taken;

    function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (core_pkg::funct3_e'(f3))
            core_pkg::F3_ADD: alu_sel = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            core_pkg::F3_SLL: alu_sel = core_pkg::ALU_SLL;
            core_pkg::F3_SLT: alu_sel = core_pkg::ALU_SLT;
            core_pkg::F3_XOR: alu_sel = core_pkg::ALU_XOR;
            core_pkg::F3_SRL: alu_sel = core_pkg::ALU_SRL;
            core_pkg::F3_OR:  alu_sel = core_pkg::ALU_OR;
            core_pkg::F3_AND: alu_sel = core_pkg::ALU_AND;
            default:          alu_sel = core_pkg::ALU_ADD;
        endcase
    endfunction

    // IF/ID, held during a load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= inst_valid; // Low after a redirect
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc   <= pc;
            id_inst <= inst;
        end
    end

    always_comb begin
        dec        = '0;
        dec.alu_op = core_pkg::ALU_ADD;
        case (id_inst.r.opcode)
            core_pkg::OP: begin
                dec.alu_op    = alu_sel(id_inst.r.funct3, id_inst.r.funct7 == core_pkg::F7_ALT);
                dec.reg_write = 1'b1;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
            end
            core_pkg::OP_IMM: begin
                dec.alu_op    = alu_sel(id_inst.i.funct3, 1'b0);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.uses_rs1  = 1'b1;
            end
            core_pkg::LOAD: begin
                dec.use_imm   = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.uses_rs1  = 1'b1;
            end
            core_pkg::STORE: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
            end
            core_pkg::BRANCH: begin
                dec.is_branch = 1'b1;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
            end
            core_pkg::JAL: begin
                dec.is_jal    = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: ;
        endcase
        ctrl = id_valid ? dec : '0; // Bubbles carry no control
    end

    assign imm_i = {{(`XLEN-12){id_inst.i.imm[11]}}, id_inst.i.imm};
    assign imm_s = {{(`XLEN-12){id_inst.i.imm[11]}}, id_inst.i.imm[11:5], id_inst.i.rd};
    assign imm_b = {{(`XLEN-12){id_inst.i.imm[11]}}, id_inst.i.rd[0], id_inst.i.imm[10:5],
                    id_inst.i.rd[4:1], 1'b0};
    assign imm_j = {{(`XLEN-20){id_inst.i.imm[11]}}, id_inst.i.rs1, id_inst.i.funct3,
                    id_inst.i.imm[0], id_inst.i.imm[10:1], 1'b0};

    // Register file, x0 never written since wb_valid excludes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `REG_NUM; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs[0] = id_inst.r.rs1;
    assign rs[1] = id_inst.r.rs2;

    // Youngest producer first
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (byp.ex_reg_write && byp.ex_rd == rs[k]) begin
                opnd[k] = byp.ex_result;
            end else if (byp.mm_reg_write && byp.mm_rd == rs[k]) begin
                opnd[k] = byp.mm_data;
            end else if (wb_valid && wb_rd == rs[k]) begin
                opnd[k] = wb_data; // Write-through
            end else begin
                opnd[k] = regs[rs[k]];
            end
        end
    end

    // Load data is not ready until the load reaches memory
    assign stall = byp.ex_is_load &&
                   ((ctrl.uses_rs1 && byp.ex_rd == rs[0]) ||
                    (ctrl.uses_rs2 && byp.ex_rd == rs[1]));

    assign taken    = ctrl.is_jal || (ctrl.is_branch && opnd[0] == opnd[1]);
    assign redirect = taken && !stall;
    assign target   = id_pc + (ctrl.is_jal ? imm_j : imm_b);

    // ID/EX
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
        end else begin
            ex_valid <= id_valid && !stall;
            ex_ctrl  <= stall ? '0 : ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd    <= id_inst.r.rd;
        ex_a     <= opnd[0];
        ex_store <= opnd[1];
        ex_pc4   <= id_pc + `XLEN'(4);
        if (ctrl.is_jal) begin
            ex_b <= '0;  // Link value passes the adder unchanged
        end else if (ctrl.use_imm) begin
            ex_b <= ctrl.mem_write ? imm_s : imm_i;
        end else begin
            ex_b <= opnd[1];
        end
    end

endmodule

// File: source/stage_if.sv
`timescale 1ns/1ps
`include "core_config.svh"

module stage_if (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] target,
    input  logic             imem_we,
    input  logic [`XLEN-1:0] imem_addr,
    input  logic [31:0]      imem_wdata,
    output logic [`XLEN-1:0] pc,
    output logic [31:0]      inst,
    output logic             inst_valid
);
    localparam int IAW = $clog2(`IMEM_DEPTH);

    logic [31:0]      imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc4;

    assign pc4 = pc + `XLEN'(4);

    // Program load port, byte address
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr[IAW+1:2]] <= imem_wdata;
        end
    end

    assign inst = imem[pc[IAW+1:2]]; // Combinational read

    // A redirect wins even with run low, the branch is already in decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (run && !stall) begin
            pc <= pc4;
        end
    end

    // Wrong-path fetch after a taken branch or jump is dropped
    assign inst_valid = run && !redirect;

endmodule

// File: source/bypass_if.sv
`timescale 1ns/1ps
`include "core_config.svh"

// Results on their way back to decode
interface bypass_if;
    logic [$clog2(`REG_NUM)-1:0] ex_rd;
    logic                        ex_reg_write; // Valid, writes a nonzero rd
    logic                        ex_is_load;
    logic [`XLEN-1:0]            ex_result;

    logic [$clog2(`REG_NUM)-1:0] mm_rd;
    logic                        mm_reg_write;
    logic [`XLEN-1:0]            mm_data;      // Load data or ALU result

    modport execute (
        output ex_rd, ex_reg_write, ex_is_load, ex_result
    );

    modport memory (
        output mm_rd, mm_reg_write, mm_data
    );

    modport decode (
        input ex_rd, ex_reg_write, ex_is_load, ex_result,
        input mm_rd, mm_reg_write, mm_data
    );
endinterface

// File: source/core_pkg.sv
package core_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    // funct3 for register and immediate arithmetic
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLL = 3'b001,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_SRL = 3'b101,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB variant

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // S, B and J immediates are rebuilt from imm, rd, rs1 and funct3
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    is_branch;
        logic    is_jal;
        logic    uses_rs1;
        logic    uses_rs2;
    } ctrl_t;

endpackage

// File: source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path and address width
`define XLEN 32

// Architectural registers, x0 reads as zero
`define REG_NUM 32

// Word counts, word index taken from address bit 2 upward
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

`endif
